//--- project.f
+incdir+rtl
rtl/mapper_pkg.sv
rtl/map_bus_if.sv
rtl/cpu_bus_port.sv
rtl/map_011.sv
rtl/map_013.sv
rtl/map_034.sv
rtl/map_hub.sv
rtl/cart_addr_map.sv
rtl/cart_top.sv
bench/cart_props.sv
bench/cart_tb.sv

//--- bench/cart_tb.sv
`timescale 1ns/10ps

module cart_tb;

	logic        clk;
	logic        reset;
	logic [7:0]  map_idx;
	logic        mir_vertical;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_data;
	logic        cpu_we;
	logic [13:0] ppu_addr;
	logic        ppu_we;
	logic [16:0] prg_addr;
	logic        prg_ce;
	logic [16:0] chr_addr;
	logic        chr_we;
	logic        ciram_ce;
	logic        ciram_a10;

	integer seed;
	int     errors;
	int     prop_fails;
	int     tests_run;
	int     tests_failed;
	int     fails_before;
	string  test_name;

	cart_top DUT (
		.clk          (clk),
		.reset        (reset),
		.map_idx      (map_idx),
		.mir_vertical (mir_vertical),
		.cpu_addr     (cpu_addr),
		.cpu_data     (cpu_data),
		.cpu_we       (cpu_we),
		.ppu_addr     (ppu_addr),
		.ppu_we       (ppu_we),
		.prg_addr     (prg_addr),
		.prg_ce       (prg_ce),
		.chr_addr     (chr_addr),
		.chr_we       (chr_we),
		.ciram_ce     (ciram_ce),
		.ciram_a10    (ciram_a10)
	);

	bind cart_top cart_props props (
		.clk          (clk),
		.reset        (reset),
		.mir_vertical (mir_vertical),
		.cpu_addr     (cpu_addr),
		.ppu_addr     (ppu_addr),
		.ppu_we       (ppu_we),
		.reg_wr       (bus.reg_wr),
		.map_out      (map_out),
		.prg_addr     (prg_addr),
		.prg_ce       (prg_ce),
		.chr_we       (chr_we),
		.ciram_ce     (ciram_ce),
		.ciram_a10    (ciram_a10)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERROR %s: expected %0h, actual %0h", name, exp, act);
			errors = errors + 1;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		fails_before = errors + prop_fails;
	endtask

	task automatic finish_test();
		tests_run = tests_run + 1;
		if (errors + prop_fails > fails_before) begin
			tests_failed = tests_failed + 1;
			$display("test %s: FAIL", test_name);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout in test %s: %s did not happen in time", test_name, what);
		$display("Regression failed");
		$finish;
	endtask

	// reset for 10 cycles with rom reads and chr writes attempted throughout.
	task automatic apply_reset(input logic [7:0] idx, input logic mir);
		logic [31:0] rnd;
		int n;
		rnd = $random(seed);
		@(posedge clk);
		reset <= 1'b1;
		map_idx <= idx;
		mir_vertical <= mir;
		cpu_we <= 1'b0;
		ppu_we <= 1'b1;
		cpu_addr <= {1'b1, rnd[14:0]};
		ppu_addr <= {1'b0, rnd[28:16]};
		for (n = 0; n < 10; n++) begin
			@(negedge clk);
			check_value({test_name, " prg_ce in reset"}, 0, prg_ce);
			check_value({test_name, " chr_we in reset"}, 0, chr_we);
			@(posedge clk);
			if (n == 9) begin
				reset <= 1'b0;
				ppu_we <= 1'b0;
			end
		end
		n = 0;
		@(negedge clk);
		while (prg_ce !== 1'b1 && n < 4) begin
			@(negedge clk);
			n = n + 1;
		end
		if (prg_ce !== 1'b1) begin
			stop_on_timeout("prg_ce after reset release");
		end
	endtask

	// one cpu write into the rom area, cpu_we high for a single cycle.
	task automatic write_reg(input logic [7:0] data);
		logic [31:0] rnd;
		rnd = $random(seed);
		@(posedge clk);
		cpu_addr <= {1'b1, rnd[14:0]};
		cpu_data <= data;
		cpu_we <= 1'b1;
		@(posedge clk);
		cpu_we <= 1'b0;
	endtask

	// the new bank is due one clock after the write cycle.
	task automatic await_prg_bank(input logic [1:0] exp, input string what);
		int n;
		n = 1;
		@(negedge clk);
		while (prg_addr[16:15] !== exp && n < 8) begin
			@(negedge clk);
			n = n + 1;
		end
		if (prg_addr[16:15] !== exp) begin
			stop_on_timeout(what);
		end else begin
			check_value({test_name, " write latency"}, 1, n);
		end
	endtask

	task automatic probe_ppu(input logic [13:0] a, input logic we, input logic [4:0] exp_bank,
			input logic exp_we);
		@(posedge clk);
		ppu_addr <= a;
		ppu_we <= we;
		@(negedge clk);
		check_value({test_name, " chr_addr"}, {exp_bank, a[11:0]}, chr_addr);
		check_value({test_name, " chr_we"}, exp_we, chr_we);
	endtask

	initial begin
		int          i;
		int          k;
		logic [31:0] rnd;
		logic [31:0] rnd2;
		logic [7:0]  data;
		logic [7:0]  first;
		logic [1:0]  bank;
		seed = 44224;
		errors = 0;
		prop_fails = 0;
		tests_run = 0;
		tests_failed = 0;
		reset = 1'b1;
		map_idx = 8'd0;
		mir_vertical = 1'b0;
		cpu_addr = 16'h0000;
		cpu_data = 8'h00;
		cpu_we = 1'b0;
		ppu_addr = 14'h0000;
		ppu_we = 1'b0;

		start_test("nominal");
		apply_reset(8'd0, 1'b0);
		for (i = 0; i < 12; i++) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			@(posedge clk);
			cpu_addr <= rnd[15:0];
			cpu_data <= rnd[23:16];
			cpu_we <= rnd[24];
			ppu_addr <= {1'b0, rnd2[12:0]};
			ppu_we <= rnd2[13];
			@(negedge clk);
			check_value({test_name, " prg_addr"}, {2'b00, rnd[14:0]}, prg_addr);
			check_value({test_name, " prg_ce"}, rnd[15], prg_ce);
			check_value({test_name, " chr_addr"}, {4'b0000, rnd2[12:0]}, chr_addr);
			check_value({test_name, " chr_we"}, 0, chr_we);
		end
		@(posedge clk);
		cpu_we <= 1'b0;
		finish_test();

		for (k = 0; k < 2; k++) begin
			if (k == 0) begin
				start_test("color dreams 11");
				apply_reset(8'd11, 1'b1);
			end else begin
				start_test("color dreams 144");
				apply_reset(8'd144, 1'b0);
			end
			for (i = 0; i < 6; i++) begin
				rnd = $random(seed);
				data = rnd[7:0];
				write_reg(data);
				await_prg_bank(data[1:0], "color dreams prg bank");
				probe_ppu({2'b00, rnd[19:8]}, 1'b1, {data[7:4], 1'b0}, 1'b0);
				probe_ppu({2'b01, rnd[31:20]}, 1'b1, {data[7:4], 1'b1}, 1'b0);
			end
			finish_test();
		end

		start_test("cprom");
		apply_reset(8'd13, 1'b0);
		for (i = 0; i < 6; i++) begin
			rnd = $random(seed);
			data = rnd[7:0];
			write_reg(data);
			probe_ppu({2'b00, rnd[19:8]}, rnd[20], 5'd0, rnd[20]);
			probe_ppu({2'b01, rnd[31:20]}, rnd[21], {3'b000, data[1:0]}, rnd[21]);
			@(posedge clk);
			ppu_addr <= {1'b1, rnd[12:0]};
			ppu_we <= 1'b1;
			@(negedge clk);
			check_value({test_name, " chr_we above $2000"}, 0, chr_we);
		end
		finish_test();

		start_test("bnrom");
		apply_reset(8'd34, 1'b1);
		bank = 2'd0;
		for (i = 0; i < 6; i++) begin
			rnd = $random(seed);
			data = {rnd[7:2], bank + 2'd1 + 2'(rnd[1:0] % 3)};
			write_reg(data);
			await_prg_bank(data[1:0], "bnrom prg bank");
			bank = data[1:0];
			probe_ppu({2'b00, rnd[19:8]}, rnd[20], 5'd0, rnd[20]);
			probe_ppu({2'b01, rnd[31:20]}, rnd[21], 5'd1, rnd[21]);
		end
		// a held cpu_we keeps only the value of its first cycle.
		rnd = $random(seed);
		first = {rnd[7:2], bank + 2'd1};
		@(posedge clk);
		cpu_addr <= {1'b1, rnd[22:8]};
		cpu_data <= first;
		cpu_we <= 1'b1;
		for (i = 0; i < 4; i++) begin
			rnd = $random(seed);
			@(posedge clk);
			cpu_data <= {rnd[7:2], first[1:0] + 2'd1 + 2'(rnd[1:0] % 3)};
			@(negedge clk);
			check_value({test_name, " held write bank"}, first[1:0], prg_addr[16:15]);
		end
		@(posedge clk);
		cpu_we <= 1'b0;
		finish_test();

		for (k = 0; k < 2; k++) begin
			if (k == 0) begin
				start_test("nametable horizontal");
			end else begin
				start_test("nametable vertical");
			end
			apply_reset(8'd0, k[0]);
			for (i = 0; i < 10; i++) begin
				rnd = $random(seed);
				@(posedge clk);
				ppu_addr <= rnd[13:0];
				ppu_we <= 1'b0;
				@(negedge clk);
				check_value({test_name, " ciram_ce"}, rnd[13], ciram_ce);
				check_value({test_name, " ciram_a10"}, k[0] ? rnd[10] : rnd[11], ciram_a10);
			end
			finish_test();
		end

		start_test("reset");
		apply_reset(8'd34, 1'b0);
		write_reg(8'h03);
		await_prg_bank(2'd3, "bnrom bank before reset");
		apply_reset(8'd34, 1'b0);
		check_value({test_name, " bnrom prg bank"}, 0, prg_addr[16:15]);
		probe_ppu(14'h0123, 1'b1, 5'd0, 1'b1);
		probe_ppu(14'h1456, 1'b1, 5'd1, 1'b1);
		apply_reset(8'd11, 1'b1);
		write_reg(8'hf2);
		await_prg_bank(2'd2, "color dreams bank before reset");
		apply_reset(8'd11, 1'b1);
		check_value({test_name, " color dreams prg bank"}, 0, prg_addr[16:15]);
		probe_ppu(14'h0abc, 1'b1, 5'd0, 1'b0);
		probe_ppu(14'h1def, 1'b1, 5'd1, 1'b0);
		apply_reset(8'd13, 1'b0);
		write_reg(8'h03);
		probe_ppu(14'h1321, 1'b0, 5'd3, 1'b0);
		apply_reset(8'd13, 1'b0);
		probe_ppu(14'h1321, 1'b0, 5'd0, 1'b0);
		finish_test();

		$display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, errors, prop_fails);
		if (tests_failed == 0 && errors == 0 && prop_fails == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- bench/cart_props.sv
`timescale 1ns/10ps
`include "mapper_defs.svh"

module cart_props import mapper_pkg::*; (
	input logic               clk,
	input logic               reset,
	input logic               mir_vertical,
	input logic [`CPU_AW-1:0] cpu_addr,
	input logic [`PPU_AW-1:0] ppu_addr,
	input logic               ppu_we,
	input logic               reg_wr,
	input map_out_t           map_out,
	input logic [`PRG_AW-1:0] prg_addr,
	input logic               prg_ce,
	input logic               chr_we,
	input logic               ciram_ce,
	input logic               ciram_a10
);

	logic mir_cfg;

	// mirroring as the board pin stood while reset was high.
	always_ff @(posedge clk) begin
		if (reset) begin
			mir_cfg <= mir_vertical;
		end
	end

	// nothing may reach the memories while reset is high.
	prg_quiet_in_reset: assert property (@(posedge clk) reset |-> !prg_ce)
		else begin
			$error("prg_ce high during reset");
			cart_tb.prop_fails = cart_tb.prop_fails + 1;
		end

	chr_quiet_in_reset: assert property (@(posedge clk) reset |-> !chr_we)
		else begin
			$error("chr_we high during reset");
			cart_tb.prop_fails = cart_tb.prop_fails + 1;
		end

	prg_window: assert property (@(posedge clk) disable iff (reset)
		prg_ce == cpu_addr[15] && prg_addr[14:0] == cpu_addr[14:0])
		else begin
			$error("prg window does not follow cpu_addr");
			cart_tb.prop_fails = cart_tb.prop_fails + 1;
		end

	// a chr write needs ram, a pattern table address and the ppu strobe.
	chr_we_ram_only: assert property (@(posedge clk)
		chr_we |-> map_out.chr_kind == CHR_RAM && !ppu_addr[13] && ppu_we)
		else begin
			$error("chr_we outside chr ram");
			cart_tb.prop_fails = cart_tb.prop_fails + 1;
		end

	ciram_select: assert property (@(posedge clk) ciram_ce == ppu_addr[13])
		else begin
			$error("ciram_ce does not follow ppu_addr[13]");
			cart_tb.prop_fails = cart_tb.prop_fails + 1;
		end

	ciram_mirror: assert property (@(posedge clk) disable iff (reset)
		ciram_a10 == (mir_cfg ? ppu_addr[10] : ppu_addr[11]))
		else begin
			$error("ciram_a10 does not match the mirroring");
			cart_tb.prop_fails = cart_tb.prop_fails + 1;
		end

	single_strobe: assert property (@(posedge clk) disable iff (reset) reg_wr |=> !reg_wr)
		else begin
			$error("register strobe longer than one cycle");
			cart_tb.prop_fails = cart_tb.prop_fails + 1;
		end

	banks_cleared: assert property (@(posedge clk)
		$fell(reset) |-> map_out.prg_bank == '0 && map_out.chr_lo_bank == '0)
		else begin
			$error("banks not cleared by reset");
			cart_tb.prop_fails = cart_tb.prop_fails + 1;
		end

endmodule

//--- rtl/cart_top.sv
`timescale 1ns/10ps
`include "mapper_defs.svh"

module cart_top import mapper_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic [7:0]         map_idx,
	input  logic               mir_vertical,
	input  logic [`CPU_AW-1:0] cpu_addr,
	input  logic [7:0]         cpu_data,
	input  logic               cpu_we,
	input  logic [`PPU_AW-1:0] ppu_addr,
	input  logic               ppu_we,
	output logic [`PRG_AW-1:0] prg_addr,
	output logic               prg_ce,
	output logic [`CHR_AW-1:0] chr_addr,
	output logic               chr_we,
	output logic               ciram_ce,
	output logic               ciram_a10
);

	map_bus_if bus ();

	map_out_t map_out;

	cpu_bus_port u_port (
		.clk          (clk),
		.reset        (reset),
		.cpu_addr     (cpu_addr),
		.cpu_data     (cpu_data),
		.cpu_we       (cpu_we),
		.map_idx      (map_idx),
		.mir_vertical (mir_vertical),
		.bus          (bus.port)
	);

	map_hub u_hub (
		.clk   (clk),
		.reset (reset),
		.bus   (bus.mapper),
		.mo    (map_out)
	);

	cart_addr_map u_addr (
		.reset     (reset),
		.cpu_addr  (cpu_addr),
		.ppu_addr  (ppu_addr),
		.ppu_we    (ppu_we),
		.mo        (map_out),
		.prg_addr  (prg_addr),
		.prg_ce    (prg_ce),
		.chr_addr  (chr_addr),
		.chr_we    (chr_we),
		.ciram_ce  (ciram_ce),
		.ciram_a10 (ciram_a10)
	);

endmodule

//--- rtl/cart_addr_map.sv
`timescale 1ns/10ps
`include "mapper_defs.svh"

module cart_addr_map import mapper_pkg::*; (
	input  logic               reset,
	input  logic [`CPU_AW-1:0] cpu_addr,
	input  logic [`PPU_AW-1:0] ppu_addr,
	input  logic               ppu_we,
	input  map_out_t           mo,
	output logic [`PRG_AW-1:0] prg_addr,
	output logic               prg_ce,
	output logic [`CHR_AW-1:0] chr_addr,
	output logic               chr_we,
	output logic               ciram_ce,
	output logic               ciram_a10
);

	logic                   chr_space;
	logic [`CHR_BANK_W-1:0] chr_bank;

	// prg window is $8000-$ffff, one 32K bank at a time.
	assign prg_addr = {mo.prg_bank, cpu_addr[14:0]};
	assign prg_ce   = cpu_addr[`CPU_AW-1] & ~reset;

	// pattern tables live below $2000.
	assign chr_space = ~ppu_addr[13];

	// ppu_addr[12] picks the lower or upper 4K half.
	assign chr_bank = ppu_addr[12] ? mo.chr_hi_bank : mo.chr_lo_bank;
	assign chr_addr = {chr_bank, ppu_addr[11:0]};

	// rom boards never see a chr write.
	assign chr_we = ppu_we & chr_space & (mo.chr_kind == CHR_RAM) & ~reset;

	// nametables go to the console's internal ram.
	assign ciram_ce = ppu_addr[13];

	always_comb begin
		if (mo.mirror == MIR_VERTICAL) begin
			ciram_a10 = ppu_addr[10];
		end else begin
			ciram_a10 = ppu_addr[11];
		end
	end

endmodule

//--- rtl/map_hub.sv
`timescale 1ns/10ps
`include "mapper_defs.svh"

module map_hub import mapper_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	map_bus_if.mapper bus,
	output map_out_t  mo
);

	map_out_t mo_nom;
	map_out_t mo_011;
	map_out_t mo_013;
	map_out_t mo_034;

	// all mappers run in parallel and see every strobe.
	map_011 m011 (
		.clk   (clk),
		.reset (reset),
		.bus   (bus),
		.mo    (mo_011)
	);

	map_013 m013 (
		.clk   (clk),
		.reset (reset),
		.bus   (bus),
		.mo    (mo_013)
	);

	map_034 m034 (
		.clk   (clk),
		.reset (reset),
		.bus   (bus),
		.mo    (mo_034)
	);

	// nrom style layout, no registers.
	always_comb begin
		mo_nom.prg_bank    = '0;
		mo_nom.chr_lo_bank = `CHR_BANK_W'(0);
		mo_nom.chr_hi_bank = `CHR_BANK_W'(1);
		mo_nom.chr_kind    = CHR_ROM;
		mo_nom.mirror      = bus.cfg.mirror;
	end

	always_comb begin
		case (bus.cfg.map_idx)
			MAP_COLOR_DREAMS, MAP_COLOR_DREAMS_ALT: mo = mo_011;
			MAP_CPROM:                              mo = mo_013;
			MAP_BNROM:                              mo = mo_034;
			default:                                mo = mo_nom;
		endcase
	end

endmodule

//--- rtl/map_034.sv
`timescale 1ns/10ps
`include "mapper_defs.svh"

module map_034 import mapper_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	map_bus_if.mapper bus,
	output map_out_t  mo
);

	logic [`PRG_BANK_W-1:0] prg_bank;

	always_ff @(posedge clk) begin
		if (reset) begin
			prg_bank <= '0;
		end else if (bus.reg_wr) begin
			prg_bank <= bus.reg_data[1:0];
		end
	end

	// chr is a fixed 8K of ram.
	always_comb begin
		mo.prg_bank    = prg_bank;
		mo.chr_lo_bank = `CHR_BANK_W'(0);
		mo.chr_hi_bank = `CHR_BANK_W'(1);
		mo.chr_kind    = CHR_RAM;
		mo.mirror      = bus.cfg.mirror;
	end

endmodule

//--- rtl/map_013.sv
`timescale 1ns/10ps
`include "mapper_defs.svh"

module map_013 import mapper_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	map_bus_if.mapper bus,
	output map_out_t  mo
);

	logic [1:0] page;

	// only the upper 4K window is switchable.
	always_ff @(posedge clk) begin
		if (reset) begin
			page <= 2'd0;
		end else if (bus.reg_wr) begin
			page <= bus.reg_data[1:0];
		end
	end

	always_comb begin
		mo.prg_bank    = '0;
		mo.chr_lo_bank = '0;
		mo.chr_hi_bank = {{(`CHR_BANK_W-2){1'b0}}, page};
		// 16K of chr ram, four pages.
		mo.chr_kind    = CHR_RAM;
		mo.mirror      = bus.cfg.mirror;
	end

endmodule

//--- rtl/map_011.sv
`timescale 1ns/10ps
`include "mapper_defs.svh"

module map_011 import mapper_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	map_bus_if.mapper bus,
	output map_out_t  mo
);

	logic [`PRG_BANK_W-1:0] prg_bank;
	logic [`CHR_BANK_W-2:0] chr_bank;

	// one register: prg in the low bits, 8K chr bank in the high nibble.
	always_ff @(posedge clk) begin
		if (reset) begin
			prg_bank <= '0;
			chr_bank <= '0;
		end else if (bus.reg_wr) begin
			prg_bank <= bus.reg_data[1:0];
			chr_bank <= bus.reg_data[7:4];
		end
	end

	always_comb begin
		mo.prg_bank    = prg_bank;
		mo.chr_lo_bank = {chr_bank, 1'b0};
		mo.chr_hi_bank = {chr_bank, 1'b1};
		mo.chr_kind    = CHR_ROM;
		mo.mirror      = bus.cfg.mirror;
	end

endmodule

//--- rtl/cpu_bus_port.sv
`timescale 1ns/10ps
`include "mapper_defs.svh"

module cpu_bus_port import mapper_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic [`CPU_AW-1:0] cpu_addr,
	input  logic [7:0]        cpu_data,
	input  logic              cpu_we,
	input  logic [7:0]        map_idx,
	input  logic              mir_vertical,
	map_bus_if.port           bus
);

	map_cfg_t cfg_q;
	logic     we_prev;
	logic     rom_area;

	// board pins are followed while reset is high, then frozen.
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q.map_idx <= map_idx;
			cfg_q.mirror  <= mir_vertical ? MIR_VERTICAL : MIR_HORIZONTAL;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			we_prev <= 1'b0;
		end else begin
			we_prev <= cpu_we;
		end
	end

	assign rom_area = cpu_addr[`CPU_AW-1];

	// rising edge of cpu_we only, so a held write strobes once.
	assign bus.reg_wr   = cpu_we & ~we_prev & rom_area;
	assign bus.reg_data = cpu_data;
	assign bus.cfg      = cfg_q;

endmodule

//--- rtl/map_bus_if.sv
`timescale 1ns/10ps

interface map_bus_if import mapper_pkg::*; ();

	// one-cycle strobe for a write into the rom area.
	logic       reg_wr;
	logic [7:0] reg_data;
	map_cfg_t   cfg;

	modport port (
		output reg_wr,
		output reg_data,
		output cfg
	);

	modport mapper (
		input reg_wr,
		input reg_data,
		input cfg
	);

endinterface

//--- rtl/mapper_pkg.sv
`include "mapper_defs.svh"

package mapper_pkg;

	// nametable arrangement seen by the ppu.
	typedef enum logic {
		MIR_HORIZONTAL = 1'b0,
		MIR_VERTICAL   = 1'b1
	} mirror_e;

	typedef enum logic {
		CHR_ROM = 1'b0,
		CHR_RAM = 1'b1
	} chr_kind_e;

	// ines numbers handled by a dedicated mapper block.
	typedef enum logic [7:0] {
		MAP_COLOR_DREAMS     = 8'd11,
		MAP_CPROM            = 8'd13,
		MAP_BNROM            = 8'd34,
		MAP_COLOR_DREAMS_ALT = 8'd144
	} map_id_e;

	// board configuration, fixed once reset is released.
	typedef struct packed {
		logic [7:0] map_idx;
		mirror_e    mirror;
	} map_cfg_t;

	// bank state produced by one mapper.
	typedef struct packed {
		logic [`PRG_BANK_W-1:0] prg_bank;
		logic [`CHR_BANK_W-1:0] chr_lo_bank;
		logic [`CHR_BANK_W-1:0] chr_hi_bank;
		chr_kind_e              chr_kind;
		mirror_e                mirror;
	} map_out_t;

endpackage

//--- rtl/mapper_defs.svh
`ifndef MAPPER_DEFS_SVH
`define MAPPER_DEFS_SVH

// cpu and ppu bus widths.
`define CPU_AW 16
`define PPU_AW 14

// physical memory widths on the cartridge side.
`define PRG_AW 17
`define CHR_AW 17

// prg banks count in 32K units.
`define PRG_BANK_W 2

// chr banks count in 4K units.
`define CHR_BANK_W 5

`endif
